// File: verification/fir_testdata.txt
# columns: input sample, expected result for that step (signed decimal)
# impulse, random stream, full-scale negative then positive run
1 0
0 0
0 0
0 0
0 0
0 0
0 -512
0 2304
1000 7168
-2500 12288
12345 12288
-7 7168
300 2304
-16384 -512
25000 -512000
-999 3584000
42 -4912640
-20000 22814464
-32768 69887232
-32768 137172992
-32768 87595008
-32768 26488320
-32768 8909312
-32768 104862976
-32768 149176832
-32768 -72542208
32767 -480017408
32767 -956815104
32767 -1241659392
32767 -1379890176
32767 -1399046144
32767 -1392508928
32767 -1426062848
32767 -1275070208
0 -805315328
0 -21248
0 805272832
0 1275027712
0 1426020352
0 1392466432

// File: project.f
logic/fir_pkg.sv
logic/fir_delay_line.sv
logic/fir_systolic_tap.sv
logic/fir_systolic_core.sv
logic/fir_sample_receiver.sv
logic/fir_result_sender.sv
logic/fir_filter_top.sv
verification/fir_filter_tb.sv

// File: Bender.yml
package:
  name: fir_filter

sources:
  - files:
      - logic/fir_pkg.sv
      - logic/fir_delay_line.sv
      - logic/fir_systolic_tap.sv
      - logic/fir_systolic_core.sv
      - logic/fir_sample_receiver.sv
      - logic/fir_result_sender.sv
      - logic/fir_filter_top.sv
  - target: test
    files:
      - verification/fir_filter_tb.sv

// File: verification/fir_filter_tb.sv
`timescale 1ns/100ps

module fir_filter_tb
    import fir_pkg::*;
;

    localparam int RESET_CYCLES    = 10;
    localparam int CYCLES_PER_LINE = 40;

    logic    clk_i;
    logic    rst_n_i;
    logic    sample_req_i;
    sample_t sample_i;
    logic    result_ack_i;
    logic    sample_ack_o;
    logic    result_req_o;
    result_t result_o;

    sample_t samples [$];
    result_t expected [$];
    int      num_lines;
    bit      data_loaded;
    integer  seed = 64;

    // previous posedge values for the link monitor
    logic    prev_sample_req;
    logic    prev_sample_ack;
    logic    prev_result_req;
    logic    prev_result_ack;
    result_t prev_result;

    fir_filter_top DUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .sample_req_i(sample_req_i),
        .sample_i    (sample_i),
        .result_ack_i(result_ack_i),
        .sample_ack_o(sample_ack_o),
        .result_req_o(result_req_o),
        .result_o    (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic check_result(input string name, input result_t exp_val, input result_t act_val);
        if (act_val !== exp_val) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp_val, act_val);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_handshake(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("MISMATCH %s expected %b actual %b", name, exp_val, act_val);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    // each data line holds a sample and the result expected for that step
    task automatic load_testdata();
        int     fd;
        string  line;
        int     s_val;
        longint e_val;
        int     fields;
        fd = $fopen("verification/fir_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/fir_testdata.txt");
            $display("TEST RESULT: FAIL");
            $fatal(1, "missing stimulus file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                fields = $sscanf(line, "%d %d", s_val, e_val);
                if (fields == 2) begin
                    samples.push_back(sample_t'(s_val));
                    expected.push_back(result_t'(e_val));
                end
            end
        end
        $fclose(fd);
        num_lines = samples.size();
        if (num_lines == 0) begin
            $display("the stimulus file holds no sample lines");
            $display("TEST RESULT: FAIL");
            $fatal(1, "empty stimulus file");
        end
        data_loaded = 1'b1;
    endtask

    // four-phase transfer of one sample, called on a falling edge
    task automatic send_sample(input sample_t value);
        sample_i     = value;
        sample_req_i = 1'b1;
        @(negedge clk_i);
        while (!sample_ack_o) begin
            @(negedge clk_i);
        end
        sample_req_i = 1'b0;
        @(negedge clk_i);
        while (sample_ack_o) begin
            @(negedge clk_i);
        end
    endtask

    task automatic drive_samples();
        foreach (samples[i]) begin
            send_sample(samples[i]);
        end
    endtask

    // random acknowledge delay stalls the sender and so the receiver
    task automatic collect_results();
        int delay;
        for (int i = 0; i < num_lines; i++) begin
            while (!result_req_o) begin
                @(negedge clk_i);
            end
            check_result($sformatf("result %0d", i), expected[i], result_o);
            delay = $unsigned($random(seed)) % 8;
            repeat (delay) @(negedge clk_i);
            result_ack_i = 1'b1;
            @(negedge clk_i);
            while (result_req_o) begin
                @(negedge clk_i);
            end
            result_ack_i = 1'b0;
        end
    endtask

    // four-phase ordering on both links
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (sample_ack_o && !prev_sample_ack) begin
                check_handshake("input ack rises after req", 1'b1, prev_sample_req);
                check_handshake("input ack held under back-pressure", 1'b0, prev_result_req);
            end
            if (!sample_ack_o && prev_sample_ack) begin
                check_handshake("input ack falls after req low", 1'b0, prev_sample_req);
            end
            if (result_req_o && !prev_result_req) begin
                check_handshake("output req rises with ack low", 1'b0, prev_result_ack);
            end
            if (!result_req_o && prev_result_req) begin
                check_handshake("output req falls after ack", 1'b1, prev_result_ack);
            end
            if (result_ack_i && !prev_result_ack) begin
                check_handshake("output ack rises after req", 1'b1, result_req_o);
            end
            if (result_req_o && prev_result_req) begin
                check_result("output data stable during req", prev_result, result_o);
            end
        end
        prev_sample_req = sample_req_i;
        prev_sample_ack = sample_ack_o;
        prev_result_req = result_req_o;
        prev_result_ack = result_ack_i;
        prev_result     = result_o;
    end

    initial begin
        wait (data_loaded);
        repeat (RESET_CYCLES + num_lines * CYCLES_PER_LINE) @(posedge clk_i);
        $display("watchdog expired before all %0d results were received", num_lines);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        rst_n_i         = 1'b0;
        sample_req_i    = 1'b0;
        sample_i        = '0;
        result_ack_i    = 1'b0;
        prev_sample_req = 1'b0;
        prev_sample_ack = 1'b0;
        prev_result_req = 1'b0;
        prev_result_ack = 1'b0;
        prev_result     = '0;
        load_testdata();
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_handshake("sample ack low after reset", 1'b0, sample_ack_o);
        check_handshake("result req low after reset", 1'b0, result_req_o);
        fork
            drive_samples();
            collect_results();
        join
        // every step has been answered, nothing else may arrive
        repeat (4) @(negedge clk_i);
        check_handshake("no extra result", 1'b0, result_req_o);
        check_handshake("input link idle", 1'b0, sample_ack_o);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: logic/fir_filter_top.sv
`timescale 1ns/100ps

module fir_filter_top
    import fir_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    sample_req_i,
    input  sample_t sample_i,
    input  logic    result_ack_i,
    output logic    sample_ack_o,
    output logic    result_req_o,
    output result_t result_o
);

    logic    step;
    logic    sender_ready;
    sample_t core_sample;
    result_t core_result;

    fir_sample_receiver u_receiver (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .sample_req_i  (sample_req_i),
        .sample_i      (sample_i),
        .sender_ready_i(sender_ready),
        .sample_ack_o  (sample_ack_o),
        .step_o        (step),
        .sample_o      (core_sample)
    );

    fir_systolic_core u_core (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .step_i  (step),
        .sample_i(core_sample),
        .result_o(core_result)
    );

    // sender also paces the receiver through its ready flag
    fir_result_sender u_sender (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .step_i       (step),
        .core_result_i(core_result),
        .result_ack_i (result_ack_i),
        .result_req_o (result_req_o),
        .result_o     (result_o),
        .ready_o      (sender_ready)
    );

endmodule

// File: logic/fir_result_sender.sv
`timescale 1ns/100ps

module fir_result_sender
    import fir_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    step_i,
    input  result_t core_result_i,
    input  logic    result_ack_i,
    output logic    result_req_o,
    output result_t result_o,
    output logic    ready_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_RTZ
    } state_t;

    state_t  state_q;
    logic    step_d_q;
    result_t result_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= S_IDLE;
            step_d_q <= 1'b0;
        end else begin
            // core result is fresh one cycle after the step
            step_d_q <= step_i;
            case (state_q)
                S_IDLE: begin
                    if (step_d_q) begin
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (result_ack_i) begin
                        state_q <= S_RTZ;
                    end
                end
                S_RTZ: begin
                    if (!result_ack_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && step_d_q) begin
            result_q <= core_result_i;
        end
    end

    assign result_req_o = (state_q == S_REQ);
    assign result_o     = result_q;
    // back-pressure until the output link is back to zero
    assign ready_o      = (state_q == S_IDLE) && !step_d_q;

    a_result_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        result_req_o |=> !result_req_o || $stable(result_o)
    );

endmodule

// File: logic/fir_sample_receiver.sv
`timescale 1ns/100ps

module fir_sample_receiver
    import fir_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    sample_req_i,
    input  sample_t sample_i,
    input  logic    sender_ready_i,
    output logic    sample_ack_o,
    output logic    step_o,
    output sample_t sample_o
);

    typedef enum logic {
        S_IDLE,
        S_ACK
    } state_t;

    state_t  state_q;
    logic    step_q;
    sample_t sample_q;
    logic    accept;

    // new request while the output side can take another result
    assign accept = (state_q == S_IDLE) && sample_req_i && sender_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            step_q  <= 1'b0;
        end else begin
            step_q <= accept;
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        state_q <= S_ACK;
                    end
                end
                S_ACK: begin
                    // return to zero before the next sample
                    if (!sample_req_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            sample_q <= sample_i;
        end
    end

    assign sample_ack_o = (state_q == S_ACK);
    assign step_o       = step_q;
    assign sample_o     = sample_q;

    // one step per request, issued with the rising acknowledge
    a_step_on_ack_rise: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        step_o |-> $rose(sample_ack_o)
    );

endmodule

// File: logic/fir_systolic_core.sv
`timescale 1ns/100ps

module fir_systolic_core
    import fir_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    step_i,
    input  sample_t sample_i,
    output result_t result_o
);

    sample_t mirror;

    // entry k feeds tap k, entry k+1 is driven by tap k
    sample_t chain_sample [TAP_NUM+1];
    result_t chain_casc   [TAP_NUM+1];

    fir_delay_line u_delay_line (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .step_i   (step_i),
        .sample_i (sample_i),
        .delayed_o(mirror)
    );

    assign chain_sample[0] = sample_i;
    assign chain_casc[0]   = '0;

    for (genvar k = 0; k < TAP_NUM; k++) begin : g_tap
        fir_systolic_tap #(
            .COEF(FIR_COEF[k])
        ) u_tap (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .step_i  (step_i),
            .sample_i(chain_sample[k]),
            .mirror_i(mirror),
            .casc_i  (chain_casc[k]),
            .sample_o(chain_sample[k+1]),
            .casc_o  (chain_casc[k+1])
        );
    end

    // the last cascade register carries the full sum
    assign result_o = chain_casc[TAP_NUM];

endmodule

// File: logic/fir_systolic_tap.sv
`timescale 1ns/100ps

module fir_systolic_tap
    import fir_pkg::*;
#(
    parameter coef_t COEF = '0
) (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    step_i,
    input  sample_t sample_i,
    input  sample_t mirror_i,
    input  result_t casc_i,
    output sample_t sample_o,
    output result_t casc_o
);

    // one extra bit so the pre-add cannot wrap
    typedef logic signed [DATA_WIDTH:0] presum_t;

    sample_t dly0_q;
    sample_t dly1_q;
    presum_t presum_q;
    result_t prod_q;
    result_t casc_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dly0_q   <= '0;
            dly1_q   <= '0;
            presum_q <= '0;
            prod_q   <= '0;
            casc_q   <= '0;
        end else if (step_i) begin
            // two stages of systolic delay toward the next tap
            dly0_q   <= sample_i;
            dly1_q   <= dly0_q;
            // tap k pairs x[n-2k-1] with the shared mirror sample
            presum_q <= presum_t'(dly0_q) + presum_t'(mirror_i);
            prod_q   <= result_t'(presum_q) * result_t'(COEF);
            casc_q   <= prod_q + casc_i;
        end
    end

    assign sample_o = dly1_q;
    assign casc_o   = casc_q;

    // the pipeline only moves on an accepted sample
    a_hold_without_step: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !step_i |=> $stable({dly0_q, dly1_q, presum_q, prod_q, casc_q})
    );

endmodule

// File: logic/fir_delay_line.sv
`timescale 1ns/100ps

module fir_delay_line
    import fir_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    step_i,
    input  sample_t sample_i,
    output sample_t delayed_o
);

    // one entry per sample of the full symmetric response
    sample_t shift_q [2*TAP_NUM];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            shift_q <= '{default: '0};
        end else if (step_i) begin
            shift_q[0] <= sample_i;
            for (int i = 1; i < 2*TAP_NUM; i++) begin
                shift_q[i] <= shift_q[i-1];
            end
        end
    end

    // oldest sample, shared by all taps as the mirrored operand
    assign delayed_o = shift_q[2*TAP_NUM-1];

endmodule

// File: logic/fir_pkg.sv
package fir_pkg;

    // physical taps, the symmetric response is twice as long
    localparam int TAP_NUM = 4;

    localparam int DATA_WIDTH = 16;
    localparam int COEF_WIDTH = 16;

    // two guard bits cover the pre-add and the cascade sum
    localparam int PRODUCT_WIDTH = DATA_WIDTH + COEF_WIDTH + 2;

    // steps from the sample that completes a sum to the result that carries it
    localparam int FIR_LATENCY = TAP_NUM + 2;

    typedef logic signed [DATA_WIDTH-1:0] sample_t;
    typedef logic signed [COEF_WIDTH-1:0] coef_t;
    typedef logic signed [PRODUCT_WIDTH-1:0] result_t;

    // tap k uses entry k
    // the mirrored half of the response reuses them in reverse order
    localparam coef_t FIR_COEF [TAP_NUM] = '{
        -16'sd512,
        16'sd2304,
        16'sd7168,
        16'sd12288
    };

endpackage
